// File: cpu_read_xbar.f
verilog/xbar_pkg.sv
verilog/master_arbiter.sv
verilog/slave_router.sv
verilog/cpu_read_xbar.sv
testbench/cpu_read_xbar_properties.sv
testbench/cpu_read_xbar_tb.sv

// File: testbench/cpu_read_xbar_tb.sv
`timescale 1ns/1ns

module cpu_read_xbar_tb;

    localparam int          ROUNDS      = 60;
    localparam int          CYCLE_LIMIT = 120 * 40;
    localparam logic [31:0] WIN_BASE    = 32'h0200_0000;
    localparam logic [31:0] WIN_LAST    = 32'h0200_ffff;
    localparam logic [31:0] SRAM_TAG    = 32'h5a00_0000;
    localparam logic [31:0] CLINT_TAG   = 32'h00c3_0000;

    logic        clock;
    logic        RESETN;
    logic [31:0] ifu_araddr, lsu_araddr, sram_araddr, clint_araddr;
    logic [31:0] ifu_rdata, lsu_rdata, sram_rdata, clint_rdata;
    logic [7:0]  ifu_arlen, lsu_arlen, sram_arlen, clint_arlen;
    logic [1:0]  ifu_rresp, lsu_rresp, sram_rresp, clint_rresp;
    logic        ifu_arvalid, ifu_arready, ifu_rlast, ifu_rvalid, ifu_rready;
    logic        lsu_arvalid, lsu_arready, lsu_rlast, lsu_rvalid, lsu_rready;
    logic        sram_arvalid, sram_arready, sram_rlast, sram_rvalid, sram_rready;
    logic        clint_arvalid, clint_arready, clint_rlast, clint_rvalid, clint_rready;

    // Index 0 is ifu or sram, index 1 is lsu or clint
    logic [31:0] seed;
    logic        m_req[2], m_arvalid[2], m_done[2];
    logic [31:0] m_addr[2];
    logic [7:0]  m_len[2];
    int          m_beats[2];
    logic        s_busy[2], s_arready[2], s_rvalid[2];
    logic [31:0] s_addr[2];
    logic [7:0]  s_len[2], s_beat[2];
    int          s_stall[2];
    int          cycles, obs_idx, cur_round, round_errs, passed, failed;
    logic        lat_seen;

    cpu_read_xbar uut (.*);

    always #10 clock = ~clock;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:16]) % n;
    endfunction

    function automatic int slave_for(logic [31:0] addr);
        return (addr >= WIN_BASE && addr <= WIN_LAST) ? 1 : 0;
    endfunction

    // Beat k of a read at A carries A + 4k xor the slave tag
    function automatic logic [31:0] beat_data(logic [31:0] addr, int k, int s);
        return (addr + 32'(4 * k)) ^ (s == 1 ? CLINT_TAG : SRAM_TAG);
    endfunction

    function automatic logic [31:0] pick_addr();
        int          kind;
        logic [31:0] r;
        kind = rand_below(4);
        r = next_rand();
        case (kind)
            0, 1:    return WIN_BASE + (r & 32'h0000_fffc);
            2:       return 32'h8000_0000 + (r & 32'h00ff_fffc);
            // Near either edge of the clint window
            default: return (r[16] ? WIN_LAST + 1 : WIN_BASE - 4) + (r & 32'hc);
        endcase
    endfunction

    task automatic value_error(string what, logic [31:0] exp, logic [31:0] act);
        $display("Error round %0d %s: expected %h, actual %h", cur_round, what, exp, act);
        round_errs++;
    endtask

    task automatic drive();
        for (int s = 0; s < 2; s++) begin
            if (s_busy[s] && !s_rvalid[s]) begin
                if (s_stall[s] > 0)
                    s_stall[s]--;
                else
                    s_rvalid[s] = 1'b1;
            end
            s_arready[s] = !s_busy[s] && (rand_below(2) == 1);
        end
        ifu_arvalid   = m_arvalid[0];
        ifu_araddr    = m_addr[0];
        ifu_arlen     = m_len[0];
        ifu_rready    = (rand_below(4) != 0);
        lsu_arvalid   = m_arvalid[1];
        lsu_araddr    = m_addr[1];
        lsu_arlen     = m_len[1];
        lsu_rready    = (rand_below(4) != 0);
        sram_arready  = s_arready[0];
        sram_rvalid   = s_rvalid[0];
        sram_rdata    = beat_data(s_addr[0], s_beat[0], 0);
        sram_rlast    = s_rvalid[0] && (s_beat[0] == s_len[0]);
        clint_arready = s_arready[1];
        clint_rvalid  = s_rvalid[1];
        clint_rdata   = beat_data(s_addr[1], s_beat[1], 1);
        clint_rlast   = s_rvalid[1] && (s_beat[1] == s_len[1]);
    endtask

    task automatic observe_master(int m, int owner, logic arready, logic rready,
                                  logic rvalid, logic rlast, logic [1:0] rresp,
                                  logic [31:0] rdata);
        int exp_s;
        exp_s = slave_for(m_addr[m]);
        if (owner != m && (arready || rvalid))
            value_error(m == 0 ? "ifu isolation" : "lsu isolation", 0, {arready, rvalid});
        if (m_arvalid[m] && arready)
            m_arvalid[m] = 1'b0;
        if (rvalid && rready) begin
            if (!m_req[m] || m_done[m]) begin
                $display("Error round %0d: %s received a beat with no burst outstanding",
                         cur_round, m == 0 ? "ifu" : "lsu");
                round_errs++;
            end else begin
                if (m == 1 && m_req[0] && !m_done[0]) begin
                    $display("Error round %0d priority: lsu got a beat before ifu finished",
                             cur_round);
                    round_errs++;
                end
                if (rresp != 2'(exp_s))
                    value_error("route", exp_s, rresp);
                if (rdata != beat_data(m_addr[m], m_beats[m], exp_s))
                    value_error("data", beat_data(m_addr[m], m_beats[m], exp_s), rdata);
                if (rlast != (m_beats[m] == m_len[m]))
                    value_error("rlast", m_beats[m] == m_len[m], rlast);
                m_beats[m]++;
                if (rlast || m_beats[m] > m_len[m])
                    m_done[m] = 1'b1;
            end
        end
    endtask

    task automatic observe_slave(int s, logic arvalid, logic [31:0] araddr,
                                 logic [7:0] arlen, logic rready);
        if (!s_busy[s] && s_arready[s] && arvalid) begin
            s_busy[s]  = 1'b1;
            s_addr[s]  = araddr;
            s_len[s]   = arlen;
            s_beat[s]  = '0;
            s_stall[s] = rand_below(3);
        end
        if (s_rvalid[s] && rready) begin
            s_rvalid[s] = 1'b0;
            s_beat[s]++;
            s_stall[s] = rand_below(3);
            if (s_beat[s] > s_len[s])
                s_busy[s] = 1'b0;
        end
    endtask

    task automatic observe();
        int owner;
        owner = (m_req[0] && !m_done[0]) ? 0 : ((m_req[1] && !m_done[1]) ? 1 : 2);
        // First slave request of a round from an idle crossbar
        if (!lat_seen && (sram_arvalid || clint_arvalid)) begin
            lat_seen = 1'b1;
            if (obs_idx != 2)
                value_error("latency", 2, obs_idx);
            if (owner < 2 && clint_arvalid != (slave_for(m_addr[owner]) == 1))
                value_error("route", slave_for(m_addr[owner]), clint_arvalid);
        end
        observe_master(0, owner, ifu_arready, ifu_rready, ifu_rvalid, ifu_rlast,
                       ifu_rresp, ifu_rdata);
        observe_master(1, owner, lsu_arready, lsu_rready, lsu_rvalid, lsu_rlast,
                       lsu_rresp, lsu_rdata);
        observe_slave(0, sram_arvalid, sram_araddr, sram_arlen, sram_rready);
        observe_slave(1, clint_arvalid, clint_araddr, clint_arlen, clint_rready);
        obs_idx++;
    endtask

    // Inputs change on the falling edge, outputs are read before the rising edge
    task automatic step();
        @(negedge clock);
        drive();
        #1;
        observe();
    endtask

    task automatic run_round(int r);
        int mode;
        mode = rand_below(4);
        cur_round = r;
        round_errs = 0;
        obs_idx = 0;
        lat_seen = 1'b0;
        for (int m = 0; m < 2; m++) begin
            m_req[m]     = (m == 0) ? (mode != 1) : (mode != 0);
            m_arvalid[m] = m_req[m];
            m_done[m]    = 1'b0;
            m_beats[m]   = 0;
            m_addr[m]    = pick_addr();
            m_len[m]     = 8'(rand_below(4));
        end
        while ((m_req[0] && !m_done[0]) || (m_req[1] && !m_done[1]))
            step();
        for (int m = 0; m < 2; m++) begin
            if (m_req[m] && m_beats[m] != m_len[m] + 1)
                value_error("beats", m_len[m] + 1, m_beats[m]);
        end
        $display("Round %0d ifu=%0d lsu=%0d: %s", r, m_req[0], m_req[1],
                 round_errs == 0 ? "ok" : "mismatch");
        if (round_errs == 0)
            passed++;
        else
            failed++;
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the rounds did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        clock = 1'b0;
        RESETN = 1'b0;
        seed = 32'hf0f0;
        passed = 0;
        failed = 0;
        for (int i = 0; i < 2; i++) begin
            m_req[i]     = 1'b0;
            m_arvalid[i] = 1'b0;
            m_done[i]    = 1'b0;
            m_addr[i]    = '0;
            m_len[i]     = '0;
            s_busy[i]    = 1'b0;
            s_rvalid[i]  = 1'b0;
            s_addr[i]    = '0;
            s_len[i]     = '0;
            s_beat[i]    = '0;
            s_stall[i]   = 0;
        end
        sram_rresp  = 2'd0;
        clint_rresp = 2'd1;
        drive();
        repeat (2) @(posedge clock);
        @(negedge clock);
        RESETN = 1'b1;
        for (int r = 0; r < ROUNDS; r++)
            run_round(r);
        $display("Rounds passed %0d, failed %0d, assertion errors %0d",
                 passed, failed, uut.props.assert_errors);
        if (failed == 0 && uut.props.assert_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: testbench/cpu_read_xbar_properties.sv
`timescale 1ns/1ns

module cpu_read_xbar_properties (
    input logic clock,
    input logic RESETN,
    input logic sram_arvalid,
    input logic clint_arvalid,
    input logic ifu_rvalid,
    input logic lsu_rvalid,
    input logic sram_rvalid,
    input logic sram_rready,
    input logic clint_rvalid,
    input logic clint_rready
);

    int   assert_errors = 0;
    logic master_rvalid;

    assign master_rvalid = ifu_rvalid || lsu_rvalid;

    one_slave_request: assert property (@(posedge clock) disable iff (!RESETN)
        !(sram_arvalid && clint_arvalid))
    else begin
        $error("sram and clint see arvalid in the same cycle");
        assert_errors++;
    end

    one_master_beat: assert property (@(posedge clock) disable iff (!RESETN)
        !(ifu_rvalid && lsu_rvalid))
    else begin
        $error("ifu and lsu see rvalid in the same cycle");
        assert_errors++;
    end

    // A stalled beat stays visible to the master
    sram_beat_held: assert property (@(posedge clock) disable iff (!RESETN)
        sram_rvalid && !sram_rready && !clint_rvalid && master_rvalid |=> master_rvalid)
    else begin
        $error("stalled sram beat dropped on the master side");
        assert_errors++;
    end

    clint_beat_held: assert property (@(posedge clock) disable iff (!RESETN)
        clint_rvalid && !clint_rready && !sram_rvalid && master_rvalid |=> master_rvalid)
    else begin
        $error("stalled clint beat dropped on the master side");
        assert_errors++;
    end

endmodule

bind cpu_read_xbar cpu_read_xbar_properties props (.*);

// File: verilog/cpu_read_xbar.sv
`timescale 1ns/1ns

module cpu_read_xbar
    import xbar_pkg::*;
#(
    parameter int                ADDR_W     = 32,
    parameter int                DATA_W     = 32,
    parameter int                LEN_W      = 8,
    parameter logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000,
    parameter logic [ADDR_W-1:0] CLINT_LAST = 32'h0200_ffff
) (
    input  logic              clock,
    input  logic              RESETN,

    input  logic [ADDR_W-1:0] ifu_araddr,
    input  logic [LEN_W-1:0]  ifu_arlen,
    input  logic              ifu_arvalid,
    output logic              ifu_arready,
    output logic [DATA_W-1:0] ifu_rdata,
    output logic [RESP_W-1:0] ifu_rresp,
    output logic              ifu_rlast,
    output logic              ifu_rvalid,
    input  logic              ifu_rready,

    input  logic [ADDR_W-1:0] lsu_araddr,
    input  logic [LEN_W-1:0]  lsu_arlen,
    input  logic              lsu_arvalid,
    output logic              lsu_arready,
    output logic [DATA_W-1:0] lsu_rdata,
    output logic [RESP_W-1:0] lsu_rresp,
    output logic              lsu_rlast,
    output logic              lsu_rvalid,
    input  logic              lsu_rready,

    output logic [ADDR_W-1:0] sram_araddr,
    output logic [LEN_W-1:0]  sram_arlen,
    output logic              sram_arvalid,
    input  logic              sram_arready,
    input  logic [DATA_W-1:0] sram_rdata,
    input  logic [RESP_W-1:0] sram_rresp,
    input  logic              sram_rlast,
    input  logic              sram_rvalid,
    output logic              sram_rready,

    output logic [ADDR_W-1:0] clint_araddr,
    output logic [LEN_W-1:0]  clint_arlen,
    output logic              clint_arvalid,
    input  logic              clint_arready,
    input  logic [DATA_W-1:0] clint_rdata,
    input  logic [RESP_W-1:0] clint_rresp,
    input  logic              clint_rlast,
    input  logic              clint_rvalid,
    output logic              clint_rready
);

    // Shared internal read bus
    logic [ADDR_W-1:0] cpu_araddr;
    logic [LEN_W-1:0]  cpu_arlen;
    logic              cpu_arvalid;
    logic              cpu_arready;
    logic [DATA_W-1:0] cpu_rdata;
    logic [RESP_W-1:0] cpu_rresp;
    logic              cpu_rlast;
    logic              cpu_rvalid;
    logic              cpu_rready;
    logic              burst_done;

    master_arbiter #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W),
        .LEN_W  (LEN_W)
    ) u_arbiter (
        .*
    );

    slave_router #(
        .ADDR_W     (ADDR_W),
        .DATA_W     (DATA_W),
        .LEN_W      (LEN_W),
        .CLINT_BASE (CLINT_BASE),
        .CLINT_LAST (CLINT_LAST)
    ) u_router (
        .*
    );

endmodule

// File: verilog/slave_router.sv
`timescale 1ns/1ns

module slave_router
    import xbar_pkg::*;
#(
    parameter int              ADDR_W     = 32,
    parameter int              DATA_W     = 32,
    parameter int              LEN_W      = 8,
    parameter logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000,
    parameter logic [ADDR_W-1:0] CLINT_LAST = 32'h0200_ffff
) (
    input  logic              clock,
    input  logic              RESETN,

    input  logic [ADDR_W-1:0] cpu_araddr,
    input  logic [LEN_W-1:0]  cpu_arlen,
    input  logic              cpu_arvalid,
    output logic              cpu_arready,
    output logic [DATA_W-1:0] cpu_rdata,
    output logic [RESP_W-1:0] cpu_rresp,
    output logic              cpu_rlast,
    output logic              cpu_rvalid,
    input  logic              cpu_rready,

    output logic              burst_done,

    output logic [ADDR_W-1:0] sram_araddr,
    output logic [LEN_W-1:0]  sram_arlen,
    output logic              sram_arvalid,
    input  logic              sram_arready,
    input  logic [DATA_W-1:0] sram_rdata,
    input  logic [RESP_W-1:0] sram_rresp,
    input  logic              sram_rlast,
    input  logic              sram_rvalid,
    output logic              sram_rready,

    output logic [ADDR_W-1:0] clint_araddr,
    output logic [LEN_W-1:0]  clint_arlen,
    output logic              clint_arvalid,
    input  logic              clint_arready,
    input  logic [DATA_W-1:0] clint_rdata,
    input  logic [RESP_W-1:0] clint_rresp,
    input  logic              clint_rlast,
    input  logic              clint_rvalid,
    output logic              clint_rready
);

    route_t route;
    logic   in_clint;
    logic   sram_sel;
    logic   clint_sel;

    // Inclusive window decode
    assign in_clint = (cpu_araddr >= CLINT_BASE) && (cpu_araddr <= CLINT_LAST);

    always_ff @(posedge clock or negedge RESETN) begin
        if (!RESETN) begin
            route <= ROUTE_IDLE;
        end else begin
            case (route)
                ROUTE_IDLE: begin
                    if (cpu_arvalid) begin
                        route <= in_clint ? ROUTE_CLINT : ROUTE_SRAM;
                    end
                end
                ROUTE_SRAM, ROUTE_CLINT: begin
                    if (burst_done) begin
                        route <= ROUTE_IDLE;
                    end
                end
                default: route <= ROUTE_IDLE;
            endcase
        end
    end

    assign sram_sel  = (route == ROUTE_SRAM);
    assign clint_sel = (route == ROUTE_CLINT);

    // Requests reach the routed slave only
    assign sram_araddr   = sram_sel  ? cpu_araddr  : '0;
    assign sram_arlen    = sram_sel  ? cpu_arlen   : '0;
    assign sram_arvalid  = sram_sel  ? cpu_arvalid : 1'b0;
    assign sram_rready   = sram_sel  ? cpu_rready  : 1'b0;

    assign clint_araddr  = clint_sel ? cpu_araddr  : '0;
    assign clint_arlen   = clint_sel ? cpu_arlen   : '0;
    assign clint_arvalid = clint_sel ? cpu_arvalid : 1'b0;
    assign clint_rready  = clint_sel ? cpu_rready  : 1'b0;

    // Return path is zero while idle
    always_comb begin
        cpu_arready = 1'b0;
        cpu_rdata   = '0;
        cpu_rresp   = '0;
        cpu_rlast   = 1'b0;
        cpu_rvalid  = 1'b0;
        if (sram_sel) begin
            cpu_arready = sram_arready;
            cpu_rdata   = sram_rdata;
            cpu_rresp   = sram_rresp;
            cpu_rlast   = sram_rlast;
            cpu_rvalid  = sram_rvalid;
        end else if (clint_sel) begin
            cpu_arready = clint_arready;
            cpu_rdata   = clint_rdata;
            cpu_rresp   = clint_rresp;
            cpu_rlast   = clint_rlast;
            cpu_rvalid  = clint_rvalid;
        end
    end

    // Final beat accepted by the master
    assign burst_done = cpu_rvalid && cpu_rlast && cpu_rready;

endmodule

// File: verilog/master_arbiter.sv
`timescale 1ns/1ns

module master_arbiter
    import xbar_pkg::*;
#(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32,
    parameter int LEN_W  = 8
) (
    input  logic              clock,
    input  logic              RESETN,

    input  logic [ADDR_W-1:0] ifu_araddr,
    input  logic [LEN_W-1:0]  ifu_arlen,
    input  logic              ifu_arvalid,
    output logic              ifu_arready,
    output logic [DATA_W-1:0] ifu_rdata,
    output logic [RESP_W-1:0] ifu_rresp,
    output logic              ifu_rlast,
    output logic              ifu_rvalid,
    input  logic              ifu_rready,

    input  logic [ADDR_W-1:0] lsu_araddr,
    input  logic [LEN_W-1:0]  lsu_arlen,
    input  logic              lsu_arvalid,
    output logic              lsu_arready,
    output logic [DATA_W-1:0] lsu_rdata,
    output logic [RESP_W-1:0] lsu_rresp,
    output logic              lsu_rlast,
    output logic              lsu_rvalid,
    input  logic              lsu_rready,

    output logic [ADDR_W-1:0] cpu_araddr,
    output logic [LEN_W-1:0]  cpu_arlen,
    output logic              cpu_arvalid,
    input  logic              cpu_arready,
    input  logic [DATA_W-1:0] cpu_rdata,
    input  logic [RESP_W-1:0] cpu_rresp,
    input  logic              cpu_rlast,
    input  logic              cpu_rvalid,
    output logic              cpu_rready,

    input  logic              burst_done
);

    grant_t grant;
    logic   ifu_sel;
    logic   lsu_sel;

    // ifu wins a tie in idle
    always_ff @(posedge clock or negedge RESETN) begin
        if (!RESETN) begin
            grant <= GRANT_IDLE;
        end else begin
            case (grant)
                GRANT_IDLE: begin
                    if (ifu_arvalid) begin
                        grant <= GRANT_IFU;
                    end else if (lsu_arvalid) begin
                        grant <= GRANT_LSU;
                    end
                end
                GRANT_IFU, GRANT_LSU: begin
                    if (burst_done) begin
                        grant <= GRANT_IDLE;
                    end
                end
                default: grant <= GRANT_IDLE;
            endcase
        end
    end

    assign ifu_sel = (grant == GRANT_IFU);
    assign lsu_sel = (grant == GRANT_LSU);

    // Owner drives the internal AR channel and rready
    always_comb begin
        cpu_araddr  = '0;
        cpu_arlen   = '0;
        cpu_arvalid = 1'b0;
        cpu_rready  = 1'b0;
        if (ifu_sel) begin
            cpu_araddr  = ifu_araddr;
            cpu_arlen   = ifu_arlen;
            cpu_arvalid = ifu_arvalid;
            cpu_rready  = ifu_rready;
        end else if (lsu_sel) begin
            cpu_araddr  = lsu_araddr;
            cpu_arlen   = lsu_arlen;
            cpu_arvalid = lsu_arvalid;
            cpu_rready  = lsu_rready;
        end
    end

    // Responses go back to the owner only
    assign ifu_arready = ifu_sel ? cpu_arready : 1'b0;
    assign ifu_rdata   = ifu_sel ? cpu_rdata   : '0;
    assign ifu_rresp   = ifu_sel ? cpu_rresp   : '0;
    assign ifu_rlast   = ifu_sel ? cpu_rlast   : 1'b0;
    assign ifu_rvalid  = ifu_sel ? cpu_rvalid  : 1'b0;

    assign lsu_arready = lsu_sel ? cpu_arready : 1'b0;
    assign lsu_rdata   = lsu_sel ? cpu_rdata   : '0;
    assign lsu_rresp   = lsu_sel ? cpu_rresp   : '0;
    assign lsu_rlast   = lsu_sel ? cpu_rlast   : 1'b0;
    assign lsu_rvalid  = lsu_sel ? cpu_rvalid  : 1'b0;

endmodule

// File: verilog/xbar_pkg.sv
package xbar_pkg;

    // Width of the AXI RRESP field
    localparam int RESP_W = 2;

    // Master currently owning the internal read bus
    typedef enum logic [1:0] {
        GRANT_IDLE = 2'd0,
        GRANT_IFU  = 2'd1,
        GRANT_LSU  = 2'd2
    } grant_t;

    // Slave the internal read bus is steered to
    typedef enum logic [1:0] {
        ROUTE_IDLE  = 2'd0,
        ROUTE_SRAM  = 2'd1,
        ROUTE_CLINT = 2'd2
    } route_t;

endpackage
